// File: include/ooo_params.svh
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// Architectural register file.
`define REG_NUM 32
`define REG_W 5
`define DATA_W 32

// Seven ROB entries, so tags 1 to 7 fit in three bits and tag 0 stays free for "ready".
`define ROB_DEPTH 7
`define TAG_W 3

// ALU reservation stations.
`define RS_NUM 4

`endif

// File: src/ooo_pkg.sv
`include "ooo_params.svh"

package ooo_pkg;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5
    } op_e;

    // Tag 0 marks a value that is architectural and ready.
    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`REG_W-1:0] reg_idx_t;

    // Wishbone write data, one instruction per word.
    typedef struct packed {
        op_e        op;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [13:0] imm;
    } instr_word_t;

    typedef struct packed {
        op_e               op;
        tag_t              tag;
        logic [`DATA_W-1:0] val1;
        tag_t              qtag1;
        logic [`DATA_W-1:0] val2;
        tag_t              qtag2;
    } disp_pkt_t;

endpackage

// File: src/ooo_ifs.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

interface dispatch_if;
    import ooo_pkg::*;
    logic               valid;
    logic [`RS_NUM-1:0] sel;
    disp_pkt_t          pkt;
    logic [`RS_NUM-1:0] busy;
    modport src (output valid, sel, pkt, input busy);
    modport dst (input valid, sel, pkt, output busy);
endinterface

interface result_if;
    import ooo_pkg::*;
    logic               valid;
    tag_t               tag;
    logic [`DATA_W-1:0] data;
    logic               grant;
    modport src (output valid, tag, data, input grant);
    modport dst (input valid, tag, data, output grant);
endinterface

interface cdb_if;
    import ooo_pkg::*;
    logic               valid;
    tag_t               tag;
    logic [`DATA_W-1:0] data;
    modport drv (output valid, tag, data);
    modport snoop (input valid, tag, data);
endinterface

// File: src/regfile.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,

    input  ooo_pkg::reg_idx_t  rs1,
    input  ooo_pkg::reg_idx_t  rs2,
    output logic [`DATA_W-1:0] rs1_data,
    output logic [`DATA_W-1:0] rs2_data,
    output ooo_pkg::tag_t      rs1_tag,
    output ooo_pkg::tag_t      rs2_tag,

    input  logic               rename_en,
    input  ooo_pkg::reg_idx_t  rename_rd,
    input  ooo_pkg::tag_t      rename_tag,

    input  logic               commit_en,
    input  ooo_pkg::reg_idx_t  commit_rd,
    input  ooo_pkg::tag_t      commit_tag,
    input  logic [`DATA_W-1:0] commit_data
);
    import ooo_pkg::*;

    logic [`DATA_W-1:0] regs [`REG_NUM];
    tag_t               tags [`REG_NUM];

    // x0 is cleared by reset and never written, so it reads zero with tag 0.
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];
    assign rs1_tag  = tags[rs1];
    assign rs2_tag  = tags[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit_en && commit_rd != '0) begin
                regs[commit_rd] <= commit_data;
                // A newer rename keeps its tag.
                if (tags[commit_rd] == commit_tag) begin
                    tags[commit_rd] <= '0;
                end
            end
            if (flush) begin
                for (int i = 0; i < `REG_NUM; i++) begin
                    tags[i] <= '0;
                end
            end else if (rename_en && rename_rd != '0) begin
                // Comes last so it wins over a commit to the same register.
                tags[rename_rd] <= rename_tag;
            end
        end
    end

endmodule

// File: src/issue_ctrl.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module issue_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,

    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [31:0]        wb_dat_i,
    output logic               wb_ack,

    output ooo_pkg::reg_idx_t  rs1,
    output ooo_pkg::reg_idx_t  rs2,
    input  logic [`DATA_W-1:0] rs1_data,
    input  logic [`DATA_W-1:0] rs2_data,
    input  ooo_pkg::tag_t      rs1_tag,
    input  ooo_pkg::tag_t      rs2_tag,
    output logic               rename_en,
    output ooo_pkg::reg_idx_t  rename_rd,
    output ooo_pkg::tag_t      rename_tag,

    output logic               alloc_req,
    output ooo_pkg::reg_idx_t  alloc_rd,
    input  ooo_pkg::tag_t      alloc_tag,
    input  logic               rob_full,
    output ooo_pkg::tag_t      look_tag1,
    input  logic               look_hit1,
    input  logic [`DATA_W-1:0] look_data1,
    output ooo_pkg::tag_t      look_tag2,
    input  logic               look_hit2,
    input  logic [`DATA_W-1:0] look_data2,

    cdb_if.snoop               cdb,
    dispatch_if.src            dsp
);
    import ooo_pkg::*;

    instr_word_t        word;
    disp_pkt_t          pkt;
    logic [`RS_NUM-1:0] free;
    logic [`RS_NUM-1:0] sel;
    logic               req;
    logic               can_issue;
    logic               take;
    logic               issue;

    assign word      = wb_dat_i;
    assign rs1       = word.rs1;
    assign rs2       = word.rs2;
    assign look_tag1 = rs1_tag;
    assign look_tag2 = rs2_tag;

    // Lowest free station.
    assign free      = ~dsp.busy;
    assign sel       = free & (~free + 1'b1);
    assign can_issue = (|free) && !rob_full;

    // Skipping the ack cycle keeps a held request from being taken twice.
    assign req   = wb_cyc && wb_stb && !wb_ack && !flush;
    // Reads and writes to x0 are acked with no effect and never enter the ROB.
    assign take  = req && (!wb_we || word.rd == '0 || can_issue);
    assign issue = req && wb_we && word.rd != '0 && can_issue;

    always_comb begin
        pkt.op  = word.op;
        pkt.tag = alloc_tag;
        if (rs1_tag == '0) begin
            pkt.val1  = rs1_data;
            pkt.qtag1 = '0;
        end else if (look_hit1) begin
            pkt.val1  = look_data1;
            pkt.qtag1 = '0;
        end else if (cdb.valid && cdb.tag == rs1_tag) begin
            pkt.val1  = cdb.data;
            pkt.qtag1 = '0;
        end else begin
            pkt.val1  = '0;
            pkt.qtag1 = rs1_tag;
        end
        if (word.op == OP_ADDI) begin
            pkt.val2  = {{(`DATA_W-14){word.imm[13]}}, word.imm};
            pkt.qtag2 = '0;
        end else if (rs2_tag == '0) begin
            pkt.val2  = rs2_data;
            pkt.qtag2 = '0;
        end else if (look_hit2) begin
            pkt.val2  = look_data2;
            pkt.qtag2 = '0;
        end else if (cdb.valid && cdb.tag == rs2_tag) begin
            pkt.val2  = cdb.data;
            pkt.qtag2 = '0;
        end else begin
            pkt.val2  = '0;
            pkt.qtag2 = rs2_tag;
        end
    end

    assign rename_en  = issue;
    assign rename_rd  = word.rd;
    assign rename_tag = alloc_tag;
    assign alloc_req  = issue;
    assign alloc_rd   = word.rd;
    assign dsp.valid  = issue;
    assign dsp.sel    = sel;
    assign dsp.pkt    = pkt;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= take;
        end
    end

endmodule

// File: src/alu_station.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module alu_station #(
    parameter int INDEX = 0
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    dispatch_if.dst dsp,
    cdb_if.snoop    cdb,
    result_if.src   res
);
    import ooo_pkg::*;

    logic               busy_q;
    logic               done_q;
    op_e                op_q;
    tag_t               tag_q;
    logic [`DATA_W-1:0] v1_q;
    logic [`DATA_W-1:0] v2_q;
    tag_t               q1_q;
    tag_t               q2_q;
    logic [`DATA_W-1:0] alu;
    logic [`DATA_W-1:0] result_q;
    logic               load;
    logic               ready;

    assign load  = dsp.valid && dsp.sel[INDEX];
    assign ready = busy_q && !done_q && q1_q == '0 && q2_q == '0;

    assign dsp.busy[INDEX] = busy_q;
    assign res.valid       = done_q;
    assign res.tag         = tag_q;
    assign res.data        = result_q;

    always_comb begin
        case (op_q)
            OP_ADD, OP_ADDI: alu = v1_q + v2_q;
            OP_SUB:          alu = v1_q - v2_q;
            OP_AND:          alu = v1_q & v2_q;
            OP_OR:           alu = v1_q | v2_q;
            OP_XOR:          alu = v1_q ^ v2_q;
            default:         alu = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (load) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
        end else if (done_q && res.grant) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (ready) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_q  <= dsp.pkt.op;
            tag_q <= dsp.pkt.tag;
            v1_q  <= dsp.pkt.val1;
            q1_q  <= dsp.pkt.qtag1;
            v2_q  <= dsp.pkt.val2;
            q2_q  <= dsp.pkt.qtag2;
        end else begin
            // Pick up pending operands from the bus.
            if (q1_q != '0 && cdb.valid && cdb.tag == q1_q) begin
                v1_q <= cdb.data;
                q1_q <= '0;
            end
            if (q2_q != '0 && cdb.valid && cdb.tag == q2_q) begin
                v2_q <= cdb.data;
                q2_q <= '0;
            end
        end
        if (ready) begin
            result_q <= alu;
        end
    end

endmodule

// File: src/rob.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module rob (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,

    input  logic               alloc_req,
    input  ooo_pkg::reg_idx_t  alloc_rd,
    output ooo_pkg::tag_t      alloc_tag,
    output logic               rob_full,
    input  ooo_pkg::tag_t      look_tag1,
    output logic               look_hit1,
    output logic [`DATA_W-1:0] look_data1,
    input  ooo_pkg::tag_t      look_tag2,
    output logic               look_hit2,
    output logic [`DATA_W-1:0] look_data2,

    result_if.dst              res [`RS_NUM],
    cdb_if.drv                 cdb,

    output logic               commit_en,
    output ooo_pkg::reg_idx_t  commit_rd,
    output ooo_pkg::tag_t      commit_tag,
    output logic [`DATA_W-1:0] commit_data,
    output logic               commit_valid
);
    import ooo_pkg::*;

    // Entry i holds tag i+1.
    logic [`TAG_W-1:0]     head_q;
    logic [`TAG_W-1:0]     tail_q;
    logic [`TAG_W-1:0]     count_q;
    reg_idx_t              rd_q [`ROB_DEPTH];
    logic [`DATA_W-1:0]    val_q [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done_q;

    logic [`RS_NUM-1:0]    res_valid;
    tag_t                  res_tag [`RS_NUM];
    logic [`DATA_W-1:0]    res_data [`RS_NUM];
    logic [`RS_NUM-1:0]    grant;
    tag_t                  sel_tag;
    logic [`DATA_W-1:0]    sel_data;
    logic [`TAG_W-1:0]     cdb_idx;
    logic [`TAG_W-1:0]     look_idx1;
    logic [`TAG_W-1:0]     look_idx2;

    function automatic logic [`TAG_W-1:0] ptr_inc(input logic [`TAG_W-1:0] p);
        return (p == `ROB_DEPTH - 1) ? '0 : p + 1'b1;
    endfunction

    for (genvar g = 0; g < `RS_NUM; g++) begin : g_res
        assign res_valid[g]  = res[g].valid;
        assign res_tag[g]    = res[g].tag;
        assign res_data[g]   = res[g].data;
        assign res[g].grant  = grant[g];
    end

    // One result per cycle, lowest station first.
    assign grant = res_valid & (~res_valid + 1'b1);

    always_comb begin
        sel_tag  = '0;
        sel_data = '0;
        for (int i = 0; i < `RS_NUM; i++) begin
            if (grant[i]) begin
                sel_tag  = res_tag[i];
                sel_data = res_data[i];
            end
        end
    end

    assign alloc_tag = tail_q + 1'b1;
    assign rob_full  = (count_q == `ROB_DEPTH);

    assign look_idx1  = look_tag1 - 1'b1;
    assign look_idx2  = look_tag2 - 1'b1;
    assign look_hit1  = look_tag1 != '0 && done_q[look_idx1];
    assign look_hit2  = look_tag2 != '0 && done_q[look_idx2];
    assign look_data1 = val_q[look_idx1];
    assign look_data2 = val_q[look_idx2];

    // The head retires in the cycle after the bus marked it done.
    assign commit_en    = count_q != '0 && done_q[head_q] && !flush;
    assign commit_valid = commit_en;
    assign commit_rd    = rd_q[head_q];
    assign commit_tag   = head_q + 1'b1;
    assign commit_data  = val_q[head_q];

    assign cdb_idx = cdb.tag - 1'b1;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_q    <= '0;
            tail_q    <= '0;
            count_q   <= '0;
            done_q    <= '0;
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= |grant;
            if (alloc_req) begin
                tail_q         <= ptr_inc(tail_q);
                done_q[tail_q] <= 1'b0;
            end
            if (cdb.valid) begin
                done_q[cdb_idx] <= 1'b1;
            end
            if (commit_en) begin
                head_q <= ptr_inc(head_q);
            end
            case ({alloc_req, commit_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cdb.tag  <= sel_tag;
        cdb.data <= sel_data;
        if (alloc_req) begin
            rd_q[tail_q] <= alloc_rd;
        end
        if (cdb.valid) begin
            val_q[cdb_idx] <= cdb.data;
        end
    end

endmodule

// File: src/ooo_core.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [31:0]        wb_dat_i,
    output logic               wb_ack,
    output logic               commit_valid,
    output ooo_pkg::reg_idx_t  commit_rd,
    output logic [`DATA_W-1:0] commit_data
);
    import ooo_pkg::*;

    dispatch_if dsp ();
    cdb_if      cdb ();
    result_if   res [`RS_NUM] ();

    reg_idx_t           rs1;
    reg_idx_t           rs2;
    logic [`DATA_W-1:0] rs1_data;
    logic [`DATA_W-1:0] rs2_data;
    tag_t               rs1_tag;
    tag_t               rs2_tag;
    logic               rename_en;
    reg_idx_t           rename_rd;
    tag_t               rename_tag;
    logic               alloc_req;
    reg_idx_t           alloc_rd;
    tag_t               alloc_tag;
    logic               rob_full;
    tag_t               look_tag1;
    tag_t               look_tag2;
    logic               look_hit1;
    logic               look_hit2;
    logic [`DATA_W-1:0] look_data1;
    logic [`DATA_W-1:0] look_data2;
    logic               commit_en;
    tag_t               commit_tag;

    regfile u_regfile (
        .clk, .rst, .flush,
        .rs1, .rs2, .rs1_data, .rs2_data, .rs1_tag, .rs2_tag,
        .rename_en, .rename_rd, .rename_tag,
        .commit_en, .commit_rd, .commit_tag, .commit_data
    );

    issue_ctrl u_issue (
        .clk, .rst, .flush,
        .wb_cyc, .wb_stb, .wb_we, .wb_dat_i, .wb_ack,
        .rs1, .rs2, .rs1_data, .rs2_data, .rs1_tag, .rs2_tag,
        .rename_en, .rename_rd, .rename_tag,
        .alloc_req, .alloc_rd, .alloc_tag, .rob_full,
        .look_tag1, .look_hit1, .look_data1,
        .look_tag2, .look_hit2, .look_data2,
        .cdb (cdb),
        .dsp (dsp)
    );

    rob u_rob (
        .clk, .rst, .flush,
        .alloc_req, .alloc_rd, .alloc_tag, .rob_full,
        .look_tag1, .look_hit1, .look_data1,
        .look_tag2, .look_hit2, .look_data2,
        .res (res),
        .cdb (cdb),
        .commit_en, .commit_rd, .commit_tag, .commit_data, .commit_valid
    );

    for (genvar g = 0; g < `RS_NUM; g++) begin : g_rs
        alu_station #(
            .INDEX (g)
        ) u_station (
            .clk, .rst, .flush,
            .dsp (dsp),
            .cdb (cdb),
            .res (res[g])
        );
    end

endmodule

// File: dv/ooo_core_properties.sv
`timescale 1ns/1ps

module ooo_core_properties (
    input logic              clk,
    input logic              rst,
    input logic              flush,
    input logic              wb_cyc,
    input logic              wb_stb,
    input logic              wb_ack,
    input logic              commit_valid,
    input ooo_pkg::reg_idx_t commit_rd
);
    int fail_count = 0;

    // A classic slave acks a held request for exactly one cycle.
    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack was high for two cycles in a row");
        end

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> wb_cyc && wb_stb)
        else begin
            fail_count++;
            $error("wb_ack arrived outside a Wishbone cycle");
        end

    // The ROB is empty after a flush.
    flush_quiet: assert property (@(posedge clk) disable iff (rst) flush |=> !commit_valid)
        else begin
            fail_count++;
            $error("commit_valid was high in the cycle after flush");
        end

    no_x0_commit: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_rd != '0)
        else begin
            fail_count++;
            $error("an instruction committed to x0");
        end

endmodule

bind ooo_core ooo_core_properties u_props (
    .clk,
    .rst,
    .flush,
    .wb_cyc,
    .wb_stb,
    .wb_ack,
    .commit_valid,
    .commit_rd
);

// File: dv/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int N_RANDOM = 300;
    localparam int N_INSTR  = N_RANDOM + 40;

    logic               clk;
    logic               rst;
    logic               flush;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [31:0]        wb_dat_i;
    logic               wb_ack;
    logic               commit_valid;
    reg_idx_t           commit_rd;
    logic [`DATA_W-1:0] commit_data;

    integer             seed;
    logic [31:0]        r;
    logic [31:0]        r2;
    logic [2:0]         op_sel;
    instr_word_t        pending [$];
    instr_word_t        head;
    logic [31:0]        model_regs [`REG_NUM];
    int                 errors;
    int                 checks;

    ooo_core u_dut (
        .clk,
        .rst,
        .flush,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_dat_i,
        .wb_ack,
        .commit_valid,
        .commit_rd,
        .commit_data
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic instr_word_t encode(input op_e op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [13:0] imm);
        instr_word_t w;
        w.op  = op;
        w.rd  = rd;
        w.rs1 = rs1;
        w.rs2 = rs2;
        w.imm = imm;
        return w;
    endfunction

    // Mostly x0 to x7, so that instructions depend on each other.
    function automatic logic [4:0] pick_reg(input logic [7:0] rnd);
        return (rnd[7:5] != 3'd0) ? {2'b00, rnd[2:0]} : rnd[4:0];
    endfunction

    // Architectural result of one instruction on the model registers.
    function automatic logic [31:0] ref_result(input instr_word_t w);
        logic [31:0] a;
        logic [31:0] b;
        a = model_regs[w.rs1];
        b = model_regs[w.rs2];
        case (w.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + {{18{w.imm[13]}}, w.imm};
            default: return 32'h0;
        endcase
    endfunction

    // Classic Wishbone cycle, held until ack.
    task automatic wb_xfer(input instr_word_t w, input logic we);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_dat_i = w;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        // Writes to x0 are dropped at issue and never commit.
        if (we && w.rd != '0) begin
            pending.push_back(w);
        end
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apply_flush();
        flush = 1'b1;
        pending.delete();
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic wait_drain();
        for (int i = 0; i < 500 && pending.size() != 0; i++) begin
            @(posedge clk);
            #1;
        end
        if (pending.size() != 0) begin
            errors++;
            $display("%0d instructions never committed", pending.size());
        end
    endtask

    // Commit monitor against the in-order model.
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            if (pending.size() == 0) begin
                errors++;
                $display("A commit to x%0d arrived with nothing outstanding", commit_rd);
            end else begin
                head = pending.pop_front();
                check("commit_rd", {27'b0, commit_rd}, {27'b0, head.rd});
                check("commit_data", commit_data, ref_result(head));
                model_regs[head.rd] = ref_result(head);
            end
        end
    end

    initial begin
        repeat (N_INSTR * 40 + 1000) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", N_INSTR * 40 + 1000);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        seed     = 32'h40ec4fc1;
        errors   = 0;
        checks   = 0;
        rst      = 1'b1;
        flush    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_dat_i = '0;
        for (int i = 0; i < `REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        check("wb_ack", {31'b0, wb_ack}, 32'h0);
        check("commit_valid", {31'b0, commit_valid}, 32'h0);
        rst = 1'b0;

        // Seed registers, one with a negative immediate.
        wb_xfer(encode(OP_ADDI, 5'd1, 5'd0, 5'd0, 14'h1234), 1'b1);
        wb_xfer(encode(OP_ADDI, 5'd2, 5'd0, 5'd0, 14'h3ffb), 1'b1);
        wait_drain();
        for (int k = 0; k < 5; k++) begin
            wb_xfer(encode(op_e'(3'(k)), 5'(10 + k), 5'd1, 5'd2, 14'd0), 1'b1);
            idle(8);
        end
        // x0 write followed by a reader of x0.
        wb_xfer(encode(OP_ADDI, 5'd0, 5'd1, 5'd0, 14'd9), 1'b1);
        wb_xfer(encode(OP_ADD, 5'd8, 5'd0, 5'd1, 14'd0), 1'b1);
        // Back-to-back chain, long enough to fill the ROB.
        repeat (6) wb_xfer(encode(OP_ADDI, 5'd3, 5'd3, 5'd0, 14'd1), 1'b1);
        wb_xfer(encode(OP_ADD, 5'd4, 5'd3, 5'd3, 14'd0), 1'b1);
        wb_xfer(encode(OP_SUB, 5'd9, 5'd4, 5'd1, 14'd0), 1'b1);
        wait_drain();
        // x5 is renamed again before its first producer commits.
        // The reader issues between the two commits of x5.
        wb_xfer(encode(OP_ADDI, 5'd3, 5'd3, 5'd0, 14'd3), 1'b1);
        wb_xfer(encode(OP_ADDI, 5'd3, 5'd3, 5'd0, 14'd5), 1'b1);
        wb_xfer(encode(OP_XOR, 5'd5, 5'd1, 5'd2, 14'd0), 1'b1);
        wb_xfer(encode(OP_ADD, 5'd5, 5'd3, 5'd1, 14'd0), 1'b1);
        idle(1);
        wb_xfer(encode(OP_ADD, 5'd7, 5'd5, 5'd0, 14'd0), 1'b1);
        wait_drain();
        // Flush with a chain in flight.
        repeat (3) wb_xfer(encode(OP_ADDI, 5'd3, 5'd3, 5'd0, 14'h0100), 1'b1);
        apply_flush();
        wb_xfer(encode(OP_ADD, 5'd12, 5'd3, 5'd5, 14'd0), 1'b1);
        wait_drain();

        for (int n = 0; n < N_RANDOM; n++) begin
            r      = $random(seed);
            r2     = $random(seed);
            op_sel = 3'(r[31:28] % 4'd6);
            wb_xfer(encode(op_e'(op_sel), pick_reg(r[27:20]), pick_reg(r[19:12]),
                           pick_reg(r[11:4]), r2[29:16]), r2[3:0] != 4'd0);
            if (r2[15:10] == 6'd0) begin
                apply_flush();
            end
            if (r2[6:4] >= 3'd5) begin
                idle(int'(r2[9:7]));
            end
        end

        wait_drain();
        errors = errors + u_dut.u_props.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
src/ooo_pkg.sv
src/ooo_ifs.sv
src/regfile.sv
src/issue_ctrl.sv
src/alu_station.sv
src/rob.sv
src/ooo_core.sv
dv/ooo_core_properties.sv
dv/ooo_core_tb.sv

// File: Makefile
SIM := obj_dir/Vooo_core_tb
SRC := sim.f $(wildcard src/*.sv dv/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRC)
	verilator --binary --assert -Wno-fatal --top-module ooo_core_tb -Mdir obj_dir -f sim.f

run: $(SIM)
	$(SIM) +verilator+error+limit+100 | tee sim.log
	@! grep -q "SOME TESTS FAILED" sim.log
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
